/* design/axi_merge_pkg.sv */
package axi_merge_pkg;

    localparam int NUM_PORTS       = 4;
    localparam int ADDR_W          = 32;
    localparam int ID_W            = 4;
    localparam int DATA_W          = 64;
    localparam int STRB_W          = DATA_W / 8;
    localparam int EXTRA_W         = 8;
    localparam int MAX_OUTSTANDING = 8;
    localparam int AGE_W           = 8;

    // a downstream id of 1 to NUM_PORTS names a port, 0 names none
    localparam int PORT_SEL_W      = 3;

    typedef logic [ADDR_W-1:0]                      addr_t;
    typedef logic [ID_W-1:0]                        axi_id_t;
    typedef logic [AGE_W-1:0]                       age_t;
    typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0]   ostd_cnt_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]           port_idx_t;

    // write address request with its sideband bits
    typedef struct packed {
        addr_t              addr;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
        logic [EXTRA_W-1:0] extras;
        axi_id_t            id;
    } aw_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } b_rsp_t;

endpackage

/* design/sync_fifo.sv */
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    cnt_t             count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            if (push && !pop) begin
                count <= count + cnt_t'(1);
            end else if (pop && !push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // head entry is visible as soon as it is written
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_t'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* design/wr_port_ingress.sv */
module wr_port_ingress (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_merge_pkg::aw_req_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_merge_pkg::w_beat_t w,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_merge_pkg::aw_req_t aw_head,
    output logic                  aw_avail,
    output axi_merge_pkg::w_beat_t w_head,
    output logic                  w_avail,
    input  logic                  aw_pop,
    input  logic                  w_pop,
    input  logic                  b_done,
    output logic                  ostd_ok
);

    import axi_merge_pkg::*;

    logic      aw_empty;
    logic      aw_full;
    logic      w_empty;
    logic      w_full;
    ostd_cnt_t ostd_cnt;

    sync_fifo #(.WIDTH($bits(aw_req_t)), .DEPTH(2)) aw_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (awvalid && awready),
        .din   (aw),
        .pop   (aw_pop),
        .dout  (aw_head),
        .empty (aw_empty),
        .full  (aw_full)
    );

    sync_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(2)) w_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (wvalid && wready),
        .din   (w),
        .pop   (w_pop),
        .dout  (w_head),
        .empty (w_empty),
        .full  (w_full)
    );

    assign awready  = !aw_full;
    assign wready   = !w_full;
    assign aw_avail = !aw_empty;
    assign w_avail  = !w_empty;

    // a grant adds one write, an upstream B retires one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ostd_cnt <= '0;
        end else if (aw_pop && !b_done) begin
            ostd_cnt <= ostd_cnt + ostd_cnt_t'(1);
        end else if (b_done && !aw_pop) begin
            ostd_cnt <= ostd_cnt - ostd_cnt_t'(1);
        end
    end

    assign ostd_ok = (ostd_cnt < ostd_cnt_t'(MAX_OUTSTANDING));

    a_b_has_write: assert property (@(posedge clk) disable iff (!rst_n)
        b_done |-> (ostd_cnt != '0));

endmodule

/* design/burst_scheduler.sv */
module burst_scheduler (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  axi_merge_pkg::aw_req_t [axi_merge_pkg::NUM_PORTS-1:0] aw_head,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               aw_avail,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               w_avail,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               ostd_ok,
    input  axi_merge_pkg::w_beat_t [axi_merge_pkg::NUM_PORTS-1:0] w_head,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]               aw_pop,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]               w_pop,
    output axi_merge_pkg::aw_req_t                            m_aw,
    output logic                                              m_awvalid,
    input  logic                                              m_awready,
    output axi_merge_pkg::w_beat_t                            m_w,
    output logic                                              m_wvalid,
    input  logic                                              m_wready,
    output axi_merge_pkg::port_idx_t                          grant_port,
    output axi_merge_pkg::axi_id_t                            grant_id
);

    import axi_merge_pkg::*;

    logic [NUM_PORTS-1:0]  eligible;
    age_t                  age [NUM_PORTS];
    logic                  win_found;
    port_idx_t             win_idx;
    age_t                  win_age;
    logic                  burst_open;
    port_idx_t             owner;
    logic                  start;
    port_idx_t             w_port;
    logic [PORT_SEL_W-1:0] tag;

    assign eligible = aw_avail & w_avail & ostd_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (aw_pop[i]) begin
                    age[i] <= '0;
                end else if (eligible[i]) begin
                    age[i] <= age[i] + age_t'(age[i] != '1);
                end
            end
        end
    end

    // oldest eligible port wins and a strict compare keeps ties on the lower index
    always_comb begin
        win_found = 1'b0;
        win_idx   = '0;
        win_age   = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (eligible[i] && age[i] != '0 && (!win_found || age[i] > win_age)) begin
                win_found = 1'b1;
                win_idx   = port_idx_t'(i);
                win_age   = age[i];
            end
        end
    end

    assign start  = win_found && !burst_open && m_awready && m_wready;
    assign w_port = start ? win_idx : owner;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_open <= 1'b0;
            owner      <= '0;
        end else if (start) begin
            burst_open <= (aw_head[win_idx].len != '0);
            owner      <= win_idx;
        end else if (m_wvalid && m_w.last) begin
            burst_open <= 1'b0;
        end
    end

    assign tag = PORT_SEL_W'(win_idx) + PORT_SEL_W'(1);

    always_comb begin
        m_aw    = aw_head[win_idx];
        m_aw.id = axi_id_t'(tag);
    end

    assign m_awvalid  = start;
    assign grant_port = win_idx;
    assign grant_id   = aw_head[win_idx].id;

    assign m_wvalid = m_wready && (start || burst_open) && w_avail[w_port];
    assign m_w      = w_head[w_port];

    always_comb begin
        aw_pop = '0;
        w_pop  = '0;
        if (start) begin
            aw_pop[win_idx] = 1'b1;
        end
        if (m_wvalid) begin
            w_pop[w_port] = 1'b1;
        end
    end

    // the beat sent with a grant closes the burst exactly when len is zero
    a_first_beat_last: assert property (@(posedge clk) disable iff (!rst_n)
        m_awvalid |-> (m_w.last == (m_aw.len == '0)));

endmodule

/* design/bresp_router.sv */
module bresp_router (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             grant_valid,
    input  axi_merge_pkg::port_idx_t                         grant_port,
    input  axi_merge_pkg::axi_id_t                           grant_id,
    input  axi_merge_pkg::b_rsp_t                            m_b,
    input  logic                                             m_bvalid,
    output logic                                             m_bready,
    output axi_merge_pkg::b_rsp_t [axi_merge_pkg::NUM_PORTS-1:0] s_b,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]              s_bvalid,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]              s_bready,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]              b_done
);

    import axi_merge_pkg::*;

    logic [NUM_PORTS-1:0]                        id_push;
    logic [NUM_PORTS-1:0]                        id_pop;
    axi_id_t [NUM_PORTS-1:0]                     id_head;
    logic                                        b_xfer;
    logic [PORT_SEL_W-1:0]                       b_sel;
    port_idx_t                                   b_port;
    b_rsp_t                                      ret_in;
    logic [$bits(port_idx_t)+$bits(b_rsp_t)-1:0] buf_dout;
    port_idx_t                                   buf_port;
    b_rsp_t                                      buf_rsp;
    logic                                        buf_empty;
    logic                                        buf_full;
    logic                                        buf_pop;

    assign b_xfer = m_bvalid && m_bready;
    assign b_sel  = m_b.id[PORT_SEL_W-1:0];
    assign b_port = port_idx_t'(b_sel - PORT_SEL_W'(1));

    always_comb begin
        id_push = '0;
        id_pop  = '0;
        if (grant_valid) begin
            id_push[grant_port] = 1'b1;
        end
        if (b_xfer) begin
            id_pop[b_port] = 1'b1;
        end
    end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_id_fifo
        sync_fifo #(.WIDTH(ID_W), .DEPTH(MAX_OUTSTANDING)) id_fifo_i (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (id_push[g]),
            .din   (grant_id),
            .pop   (id_pop[g]),
            .dout  (id_head[g]),
            .empty (),
            .full  ()
        );
    end

    // the original id is restored before the response is buffered
    assign ret_in.id   = id_head[b_port];
    assign ret_in.resp = m_b.resp;

    sync_fifo #(.WIDTH($bits(port_idx_t) + $bits(b_rsp_t)), .DEPTH(2)) b_buf_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_xfer),
        .din   ({b_port, ret_in}),
        .pop   (buf_pop),
        .dout  (buf_dout),
        .empty (buf_empty),
        .full  (buf_full)
    );

    assign {buf_port, buf_rsp} = buf_dout;
    assign m_bready = !buf_full;

    always_comb begin
        s_bvalid = '0;
        if (!buf_empty) begin
            s_bvalid[buf_port] = 1'b1;
        end
    end

    assign s_b     = {NUM_PORTS{buf_rsp}};
    assign buf_pop = !buf_empty && s_bready[buf_port];
    assign b_done  = s_bvalid & s_bready;

    a_bid_range: assert property (@(posedge clk) disable iff (!rst_n)
        m_bvalid |-> (m_b.id inside {[1:NUM_PORTS]}));

endmodule

/* design/axi_wr_merger.sv */
module axi_wr_merger (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  axi_merge_pkg::aw_req_t [axi_merge_pkg::NUM_PORTS-1:0] s_aw,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               s_awvalid,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]               s_awready,
    input  axi_merge_pkg::w_beat_t [axi_merge_pkg::NUM_PORTS-1:0] s_w,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               s_wvalid,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]               s_wready,
    output axi_merge_pkg::b_rsp_t [axi_merge_pkg::NUM_PORTS-1:0]  s_b,
    output logic [axi_merge_pkg::NUM_PORTS-1:0]               s_bvalid,
    input  logic [axi_merge_pkg::NUM_PORTS-1:0]               s_bready,
    output axi_merge_pkg::aw_req_t                            m_aw,
    output logic                                              m_awvalid,
    input  logic                                              m_awready,
    output axi_merge_pkg::w_beat_t                            m_w,
    output logic                                              m_wvalid,
    input  logic                                              m_wready,
    input  axi_merge_pkg::b_rsp_t                             m_b,
    input  logic                                              m_bvalid,
    output logic                                              m_bready
);

    import axi_merge_pkg::*;

    aw_req_t [NUM_PORTS-1:0] aw_head;
    logic [NUM_PORTS-1:0]    aw_avail;
    w_beat_t [NUM_PORTS-1:0] w_head;
    logic [NUM_PORTS-1:0]    w_avail;
    logic [NUM_PORTS-1:0]    ostd_ok;
    logic [NUM_PORTS-1:0]    aw_pop;
    logic [NUM_PORTS-1:0]    w_pop;
    logic [NUM_PORTS-1:0]    b_done;
    port_idx_t               grant_port;
    axi_id_t                 grant_id;
    logic                    grant_valid;

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        wr_port_ingress wr_port_ingress_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .aw       (s_aw[g]),
            .awvalid  (s_awvalid[g]),
            .awready  (s_awready[g]),
            .w        (s_w[g]),
            .wvalid   (s_wvalid[g]),
            .wready   (s_wready[g]),
            .aw_head  (aw_head[g]),
            .aw_avail (aw_avail[g]),
            .w_head   (w_head[g]),
            .w_avail  (w_avail[g]),
            .aw_pop   (aw_pop[g]),
            .w_pop    (w_pop[g]),
            .b_done   (b_done[g]),
            .ostd_ok  (ostd_ok[g])
        );
    end

    burst_scheduler burst_scheduler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .aw_head    (aw_head),
        .aw_avail   (aw_avail),
        .w_avail    (w_avail),
        .ostd_ok    (ostd_ok),
        .w_head     (w_head),
        .aw_pop     (aw_pop),
        .w_pop      (w_pop),
        .m_aw       (m_aw),
        .m_awvalid  (m_awvalid),
        .m_awready  (m_awready),
        .m_w        (m_w),
        .m_wvalid   (m_wvalid),
        .m_wready   (m_wready),
        .grant_port (grant_port),
        .grant_id   (grant_id)
    );

    // the scheduler only raises awvalid with awready high, so this marks each grant
    assign grant_valid = m_awvalid && m_awready;

    bresp_router bresp_router_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .grant_valid (grant_valid),
        .grant_port  (grant_port),
        .grant_id    (grant_id),
        .m_b         (m_b),
        .m_bvalid    (m_bvalid),
        .m_bready    (m_bready),
        .s_b         (s_b),
        .s_bvalid    (s_bvalid),
        .s_bready    (s_bready),
        .b_done      (b_done)
    );

endmodule

/* tb/axi_slave_model.sv */
module axi_slave_model #(
    parameter int unsigned SEED = 40
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_merge_pkg::aw_req_t m_aw,
    input  logic                   m_awvalid,
    output logic                   m_awready,
    input  axi_merge_pkg::w_beat_t m_w,
    input  logic                   m_wvalid,
    output logic                   m_wready,
    output axi_merge_pkg::b_rsp_t  m_b,
    output logic                   m_bvalid,
    input  logic                   m_bready,
    output int                     errors
);

    timeunit 1ns;
    timeprecision 100ps;

    import axi_merge_pkg::*;

    int unsigned state;
    axi_id_t     pend_id [$];
    int          pend_due [$];
    int          ostd [16];
    int          cycle;
    int          bursts_done;
    logic        b_taken;

    function int unsigned next_rand();
        state = state * 32'd1664525 + 32'd1013904223;
        return state >> 8;
    endfunction

    initial begin
        state       = SEED;
        errors      = 0;
        cycle       = 0;
        bursts_done = 0;
        b_taken     = 1'b0;
        m_awready   = 1'b0;
        m_wready    = 1'b0;
        m_bvalid    = 1'b0;
        m_b         = '0;
        for (int i = 0; i < 16; i++) begin
            ostd[i] = 0;
        end
        forever begin
            @(negedge clk);
            if (rst_n && m_awvalid && m_awready) begin
                assert (ostd[m_aw.id] < MAX_OUTSTANDING) else begin
                    errors++;
                    $display("awid %h has more than %0d writes outstanding downstream",
                             m_aw.id, MAX_OUTSTANDING);
                end
                ostd[m_aw.id]++;
                pend_id.push_back(m_aw.id);
                pend_due.push_back(cycle + 1 + int'(next_rand() % 12));
            end
            if (rst_n && m_wvalid && m_wready && m_w.last) begin
                bursts_done++;
            end
            if (rst_n && m_bvalid && m_bready) begin
                ostd[m_b.id]--;
                b_taken = 1'b1;
            end
            @(posedge clk);
            #1;
            cycle++;
            // ready does not wait for valid, the merger depends on it
            m_awready = (next_rand() % 4 != 0);
            m_wready  = (next_rand() % 4 != 0);
            if (b_taken) begin
                m_bvalid = 1'b0;
                b_taken  = 1'b0;
            end
            // a response leaves once its last beat was taken and its delay ran out
            if (!m_bvalid && pend_id.size() > 0 && bursts_done > 0 && cycle >= pend_due[0]) begin
                m_b.id   = pend_id.pop_front();
                m_b.resp = 2'(next_rand());
                m_bvalid = 1'b1;
                void'(pend_due.pop_front());
                bursts_done--;
            end
        end
    end

endmodule

/* tb/tb_axi_wr_merger.sv */
module tb_axi_wr_merger;

    timeunit 1ns;
    timeprecision 100ps;

    import axi_merge_pkg::*;

    localparam int BURSTS    = 30;
    localparam int MAX_BEATS = BURSTS * 8;
    localparam int TOTAL_B   = NUM_PORTS * BURSTS;
    localparam int TIMEOUT   = 20000;
    localparam int B_STALL   = 512;

    logic                    clk;
    logic                    rst_n;
    aw_req_t [NUM_PORTS-1:0] s_aw;
    logic [NUM_PORTS-1:0]    s_awvalid;
    logic [NUM_PORTS-1:0]    s_awready;
    w_beat_t [NUM_PORTS-1:0] s_w;
    logic [NUM_PORTS-1:0]    s_wvalid;
    logic [NUM_PORTS-1:0]    s_wready;
    b_rsp_t [NUM_PORTS-1:0]  s_b;
    logic [NUM_PORTS-1:0]    s_bvalid;
    logic [NUM_PORTS-1:0]    s_bready;
    aw_req_t                 m_aw;
    logic                    m_awvalid;
    logic                    m_awready;
    w_beat_t                 m_w;
    logic                    m_wvalid;
    logic                    m_wready;
    b_rsp_t                  m_b;
    logic                    m_bvalid;
    logic                    m_bready;

    // generated traffic per port doubles as the expected stream
    aw_req_t              aw_list [NUM_PORTS][BURSTS];
    w_beat_t              w_list [NUM_PORTS][MAX_BEATS];
    logic [1:0]           resp_seen [NUM_PORTS][BURSTS];
    int                   w_total [NUM_PORTS];
    int                   aw_drv [NUM_PORTS];
    int                   w_drv [NUM_PORTS];
    int                   aw_chk [NUM_PORTS];
    int                   w_chk [NUM_PORTS];
    int                   b_chk [NUM_PORTS];
    int                   resp_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] aw_fire;
    logic [NUM_PORTS-1:0] w_fire;
    int                   owner;
    int                   beats_left;
    int                   b_count;
    int                   errors;
    int                   slave_errors;
    int                   cycles;
    logic                 started;
    int unsigned          seed = 40;

    axi_wr_merger axi_wr_merger_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_b       (m_b),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready)
    );

    axi_slave_model #(.SEED(40)) axi_slave_model_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_b       (m_b),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready),
        .errors    (slave_errors)
    );

    function int unsigned next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    task automatic build_stimulus();
        aw_req_t aw;
        w_beat_t w;
        for (int p = 0; p < NUM_PORTS; p++) begin
            w_total[p] = 0;
            for (int k = 0; k < BURSTS; k++) begin
                aw.addr       = addr_t'((next_rand() << 16) ^ next_rand());
                aw.len        = 8'(next_rand() % 8);
                aw.size       = 3'(next_rand());
                aw.burst      = 2'(next_rand());
                aw.extras     = EXTRA_W'(next_rand());
                aw.id         = axi_id_t'(next_rand());
                aw_list[p][k] = aw;
                for (int b = 0; b <= int'(aw.len); b++) begin
                    w.data = {32'(next_rand()), 32'(next_rand())};
                    w.strb = STRB_W'(next_rand());
                    w.last = (b == int'(aw.len));
                    w_list[p][w_total[p]] = w;
                    w_total[p]++;
                end
            end
        end
    endtask

    task automatic check_reset_state();
        assert (!m_awvalid && !m_wvalid && s_bvalid == '0) else begin
            errors++;
            $display("Fail valid after reset: m_awvalid %h, m_wvalid %h, s_bvalid %h",
                     m_awvalid, m_wvalid, s_bvalid);
        end
        assert (s_awready == '1 && s_wready == '1 && m_bready) else begin
            errors++;
            $display("Fail ready after reset: s_awready %h, s_wready %h, m_bready %h",
                     s_awready, s_wready, m_bready);
        end
    endtask

    task automatic check_aw();
        int      p;
        aw_req_t exp;
        p = int'(m_aw.id) - 1;
        assert (beats_left == 0) else begin
            errors++;
            $display("downstream AW arrived while a burst was still open");
        end
        assert (p >= 0 && p < NUM_PORTS && aw_chk[p] < BURSTS) else begin
            errors++;
            $display("Fail m_aw.id: got %h, expected a port with a pending request", m_aw.id);
            return;
        end
        exp    = aw_list[p][aw_chk[p]];
        exp.id = axi_id_t'(p + 1);
        assert (m_aw == exp) else begin
            errors++;
            $display("Fail m_aw on port %0d: got %h, expected %h", p, m_aw, exp);
        end
        aw_chk[p]++;
        owner      = p;
        beats_left = int'(exp.len) + 1;
    endtask

    task automatic check_w();
        w_beat_t exp;
        assert (beats_left > 0) else begin
            errors++;
            $display("downstream W beat arrived outside any burst");
            return;
        end
        exp = w_list[owner][w_chk[owner]];
        assert (m_w == exp) else begin
            errors++;
            $display("Fail m_w from port %0d: got %h, expected %h", owner, m_w, exp);
        end
        assert (m_w.last == (beats_left == 1)) else begin
            errors++;
            $display("Fail m_w.last: got %h, expected %h", m_w.last, beats_left == 1);
        end
        w_chk[owner]++;
        beats_left--;
    endtask

    task automatic record_resp();
        int p;
        p = int'(m_b.id) - 1;
        if (p >= 0 && p < NUM_PORTS && resp_cnt[p] < BURSTS) begin
            resp_seen[p][resp_cnt[p]] = m_b.resp;
            resp_cnt[p]++;
        end
    endtask

    task automatic check_b(input int p);
        b_rsp_t exp;
        assert (b_chk[p] < resp_cnt[p]) else begin
            errors++;
            $display("port %0d returned a B response that the slave never sent", p);
            return;
        end
        exp.id   = aw_list[p][b_chk[p]].id;
        exp.resp = resp_seen[p][b_chk[p]];
        assert (s_b[p] == exp) else begin
            errors++;
            $display("Fail s_b[%0d]: got %h, expected %h", p, s_b[p], exp);
        end
        b_chk[p]++;
        b_count++;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // upstream masters, AW and W run independently of each other
    always begin
        @(posedge clk);
        #1;
        if (started) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (aw_fire[p]) begin
                    aw_drv[p]++;
                    s_awvalid[p] = 1'b0;
                end
                if (!s_awvalid[p] && aw_drv[p] < BURSTS && next_rand() % 3 != 0) begin
                    s_aw[p]      = aw_list[p][aw_drv[p]];
                    s_awvalid[p] = 1'b1;
                end
                if (w_fire[p]) begin
                    w_drv[p]++;
                    s_wvalid[p] = 1'b0;
                end
                if (!s_wvalid[p] && w_drv[p] < w_total[p] && next_rand() % 3 != 0) begin
                    s_w[p]      = w_list[p][w_drv[p]];
                    s_wvalid[p] = 1'b1;
                end
                // every other window holds B back so each port runs into its outstanding limit
                s_bready[p] = (cycles % (2 * B_STALL) < B_STALL) && (next_rand() % 4 != 0);
            end
        end
    end

    // mid-cycle sampling sees what transfers on the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            aw_fire = s_awvalid & s_awready;
            w_fire  = s_wvalid & s_wready;
            if (m_awvalid && m_awready) begin
                check_aw();
            end
            if (m_wvalid && m_wready) begin
                check_w();
            end
            if (m_bvalid && m_bready) begin
                record_resp();
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (s_bvalid[p] && s_bready[p]) begin
                    check_b(p);
                end
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        started    = 1'b0;
        s_aw       = '0;
        s_awvalid  = '0;
        s_w        = '0;
        s_wvalid   = '0;
        s_bready   = '0;
        aw_fire    = '0;
        w_fire     = '0;
        owner      = 0;
        beats_left = 0;
        b_count    = 0;
        errors     = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            aw_drv[p]   = 0;
            w_drv[p]    = 0;
            aw_chk[p]   = 0;
            w_chk[p]    = 0;
            b_chk[p]    = 0;
            resp_cnt[p] = 0;
        end
        build_stimulus();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();
        started = 1'b1;
        cycles  = 0;
        while (b_count < TOTAL_B && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (b_count == TOTAL_B) else begin
            errors++;
            $display("timed out after %0d cycles with %0d of %0d B responses returned",
                     cycles, b_count, TOTAL_B);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (aw_chk[p] == BURSTS && w_chk[p] == w_total[p]) else begin
                errors++;
                $display("port %0d did not send all of its requests and beats downstream", p);
            end
        end
        $display("errors: scoreboard %0d, slave model %0d", errors, slave_errors);
        if (errors == 0 && slave_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* axi_wr_merger.f */
design/axi_merge_pkg.sv
design/sync_fifo.sv
design/wr_port_ingress.sv
design/burst_scheduler.sv
design/bresp_router.sv
design/axi_wr_merger.sv
tb/axi_slave_model.sv
tb/tb_axi_wr_merger.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI write merger testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_wr_merger \
    -f axi_wr_merger.f

./obj_dir/Vtb_axi_wr_merger | tee sim.log

grep -F -q "** PASS **" sim.log
echo "simulation passed"
